// ==== hdl/afifo_consts.svh ====
`ifndef AFIFO_CONSTS_SVH
`define AFIFO_CONSTS_SVH

//////////////////////////////////////////////////
// Word and lane geometry
//////////////////////////////////////////////////
`define AFIFO_DSIZE 144                 // Full word width
`define AFIFO_LANE  (`AFIFO_DSIZE / 2)  // One bank lane, 72 bits

//////////////////////////////////////////////////
// Addressing
//////////////////////////////////////////////////
`define AFIFO_AW    9                   // Bank address width
`define AFIFO_DEPTH (1 << `AFIFO_AW)    // Words per bank, 512

`endif

// ==== hdl/afifo_pkg.sv ====
`default_nettype none

`include "afifo_consts.svh"

package afifo_pkg;

    typedef logic [`AFIFO_LANE-1:0] lane_t;   // One bank lane
    typedef logic [`AFIFO_AW-1:0]   addr_t;   // Bank address
    typedef logic [`AFIFO_AW:0]     ptr_t;    // Address plus wrap bit
    typedef logic [`AFIFO_AW-1:0]   count_t;  // Occupancy count

    typedef struct packed {
        lane_t hi;                            // Bits 143..72
        lane_t lo;                            // Bits 71..0
    } word_t;

    //////////////////////////////////////////////////
    // Gray code helpers, shared by both sides
    //////////////////////////////////////////////////
    function automatic ptr_t bin2gray(input ptr_t b);
        return b ^ (b >> 1);                  // Adjacent bit xor
    endfunction

    function automatic ptr_t gray2bin(input ptr_t g);
        ptr_t b;
        b[`AFIFO_AW] = g[`AFIFO_AW];          // MSB passes through
        for (int i = `AFIFO_AW - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];             // Running xor downward
        end
        return b;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/afifo_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "afifo_consts.svh"

module afifo_bank (
    input  logic             wr_clk,
    input  logic             we,
    input  afifo_pkg::addr_t waddr,
    input  afifo_pkg::lane_t wdata,
    input  afifo_pkg::addr_t raddr,
    output afifo_pkg::lane_t rdata
);

    // Storage for one lane, no reset like block RAM
    afifo_pkg::lane_t mem [0:`AFIFO_DEPTH-1];

    //////////////////////////////////////////////////
    // Write port on wr_clk
    //////////////////////////////////////////////////
    always_ff @(posedge wr_clk) begin
        if (we) begin
            mem[waddr] <= wdata;              // Strobe already gated by full
        end
    end

    //////////////////////////////////////////////////
    // Read port, asynchronous
    //////////////////////////////////////////////////
    // Head word shows without a read cycle, hence FWFT
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

// ==== hdl/afifo_wr_side.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "afifo_consts.svh"

module afifo_wr_side (
    input  logic              wr_clk,
    input  logic              RST,
    input  logic              wr_en,
    input  afifo_pkg::ptr_t   rptr_gray,
    output logic              we,
    output afifo_pkg::addr_t  waddr,
    output afifo_pkg::ptr_t   wptr_gray,
    output logic              full,
    output afifo_pkg::count_t wcount
);

    afifo_pkg::ptr_t wbin;                    // Binary write pointer
    afifo_pkg::ptr_t wbin_next;
    afifo_pkg::ptr_t wgray_next;
    afifo_pkg::ptr_t rq1;                     // Sync stage 1
    afifo_pkg::ptr_t rq2;                     // Sync stage 2
    afifo_pkg::ptr_t rbin_sync;               // Read pointer, write domain
    afifo_pkg::ptr_t used_next;               // Occupancy after this edge
    logic            full_next;

    assign we         = wr_en & ~full;        // Drop writes while full
    assign waddr      = wbin[`AFIFO_AW-1:0];
    assign wbin_next  = wbin + afifo_pkg::ptr_t'(we);
    assign wgray_next = afifo_pkg::bin2gray(wbin_next);
    assign rbin_sync  = afifo_pkg::gray2bin(rq2);
    assign used_next  = wbin_next - rbin_sync; // Modulo 1024

    // Full when one lap ahead, top two Gray bits flipped
    assign full_next = (wgray_next == {~rq2[`AFIFO_AW -: 2], rq2[`AFIFO_AW-2:0]});

    //////////////////////////////////////////////////
    // Read pointer synchronizer
    //////////////////////////////////////////////////
    always_ff @(posedge wr_clk or posedge RST) begin
        if (RST) begin
            rq1 <= '0;
            rq2 <= '0;
        end else begin
            rq1 <= rptr_gray;                 // Gray, one bit moves at a time
            rq2 <= rq1;
        end
    end

    //////////////////////////////////////////////////
    // Pointers, full and count
    //////////////////////////////////////////////////
    always_ff @(posedge wr_clk or posedge RST) begin
        if (RST) begin
            wbin      <= '0;
            wptr_gray <= '0;
            full      <= 1'b0;
            wcount    <= '0;
        end else begin
            wbin      <= wbin_next;
            wptr_gray <= wgray_next;          // Registered for clean crossing
            full      <= full_next;
            // Saturate at 511 so count and flag move together
            wcount    <= full_next ? '1 : used_next[`AFIFO_AW-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/afifo_rd_side.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "afifo_consts.svh"

module afifo_rd_side (
    input  logic              rd_clk,
    input  logic              RST,
    input  logic              rd_en,
    input  afifo_pkg::ptr_t   wptr_gray,
    output afifo_pkg::addr_t  raddr,
    output afifo_pkg::ptr_t   rptr_gray,
    output logic              empty,
    output afifo_pkg::count_t rcount
);

    afifo_pkg::ptr_t rbin;                    // Binary read pointer
    afifo_pkg::ptr_t rbin_next;
    afifo_pkg::ptr_t rgray_next;
    afifo_pkg::ptr_t wq1;                     // Sync stage 1
    afifo_pkg::ptr_t wq2;                     // Sync stage 2
    afifo_pkg::ptr_t wbin_sync;               // Write pointer, read domain
    afifo_pkg::ptr_t avail_next;              // Words left after this edge
    logic            re;
    logic            empty_next;

    assign re         = rd_en & ~empty;       // No pop from an empty FIFO
    assign raddr      = rbin[`AFIFO_AW-1:0];  // Always the head word
    assign rbin_next  = rbin + afifo_pkg::ptr_t'(re);
    assign rgray_next = afifo_pkg::bin2gray(rbin_next);
    assign wbin_sync  = afifo_pkg::gray2bin(wq2);
    assign avail_next = wbin_sync - rbin_next;
    assign empty_next = (rgray_next == wq2);  // Caught up with the writer

    //////////////////////////////////////////////////
    // Write pointer synchronizer
    //////////////////////////////////////////////////
    always_ff @(posedge rd_clk or posedge RST) begin
        if (RST) begin
            wq1 <= '0;
            wq2 <= '0;
        end else begin
            wq1 <= wptr_gray;
            wq2 <= wq1;                       // Settled copy
        end
    end

    //////////////////////////////////////////////////
    // Pointers, empty and count
    //////////////////////////////////////////////////
    always_ff @(posedge rd_clk or posedge RST) begin
        if (RST) begin
            rbin      <= '0;
            rptr_gray <= '0;
            empty     <= 1'b1;                // Nothing to show after reset
            rcount    <= '0;
        end else begin
            rbin      <= rbin_next;
            rptr_gray <= rgray_next;
            empty     <= empty_next;
            if (empty_next) begin
                rcount <= '0;                 // Held at zero while empty
            end else if (avail_next[`AFIFO_AW]) begin
                rcount <= '1;                 // 512 does not fit in 9 bits
            end else begin
                rcount <= avail_next[`AFIFO_AW-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/afifo_144.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "afifo_consts.svh"

module afifo_144 (
    input  logic              wr_clk,
    input  logic              rd_clk,
    input  logic              RST,
    input  afifo_pkg::word_t  din,
    input  logic              wr_en,
    input  logic              rd_en,
    output afifo_pkg::word_t  dout,
    output logic              full,
    output logic              empty,
    output afifo_pkg::count_t wcount,
    output afifo_pkg::count_t rcount
);

    logic             we;                     // Write strobe to both banks
    afifo_pkg::addr_t waddr;
    afifo_pkg::addr_t raddr;                  // Head address
    afifo_pkg::ptr_t  wptr_gray;              // Crosses to rd_clk
    afifo_pkg::ptr_t  rptr_gray;              // Crosses to wr_clk

    //////////////////////////////////////////////////
    // Pointer and flag logic, one per clock domain
    //////////////////////////////////////////////////
    afifo_wr_side u_wr_side (
        .wr_clk    (wr_clk),
        .RST       (RST),
        .wr_en     (wr_en),
        .rptr_gray (rptr_gray),
        .we        (we),
        .waddr     (waddr),
        .wptr_gray (wptr_gray),
        .full      (full),
        .wcount    (wcount)
    );

    afifo_rd_side u_rd_side (
        .rd_clk    (rd_clk),
        .RST       (RST),
        .rd_en     (rd_en),
        .wptr_gray (wptr_gray),
        .raddr     (raddr),
        .rptr_gray (rptr_gray),
        .empty     (empty),
        .rcount    (rcount)
    );

    //////////////////////////////////////////////////
    // Two 72-bit lanes share one address pair
    //////////////////////////////////////////////////
    afifo_bank bank_lo (
        .wr_clk (wr_clk),
        .we     (we),
        .waddr  (waddr),
        .wdata  (din.lo),                     // Bits 71..0
        .raddr  (raddr),
        .rdata  (dout.lo)
    );

    afifo_bank bank_hi (
        .wr_clk (wr_clk),
        .we     (we),
        .waddr  (waddr),
        .wdata  (din.hi),                     // Bits 143..72
        .raddr  (raddr),
        .rdata  (dout.hi)
    );

endmodule

`default_nettype wire

// ==== bench/afifo_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module afifo_chk (
    input logic              wr_clk,
    input logic              rd_clk,
    input logic              RST,
    input logic              we,                // Bank write strobe
    input logic              full,
    input logic              empty,
    input afifo_pkg::count_t wcount,
    input afifo_pkg::count_t rcount
);

    //////////////////////////////////////////////////
    // Write domain
    //////////////////////////////////////////////////
    a_full_known: assert property (@(posedge wr_clk) disable iff (RST) !$isunknown(full))
        else $error("full flag is unknown");
    a_full_count: assert property (@(posedge wr_clk) disable iff (RST) full |-> wcount == '1)
        else $error("wcount not held at 511 while full");   // All ones is 511
    a_no_write_full: assert property (@(posedge wr_clk) disable iff (RST) full |-> !we)
        else $error("bank write strobe while full");

    //////////////////////////////////////////////////
    // Read domain
    //////////////////////////////////////////////////
    a_empty_known: assert property (@(posedge rd_clk) disable iff (RST) !$isunknown(empty))
        else $error("empty flag is unknown");
    a_empty_count: assert property (@(posedge rd_clk) disable iff (RST) empty |-> rcount == '0)
        else $error("rcount not zero while empty");

endmodule

`default_nettype wire

// ==== bench/afifo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "afifo_consts.svh"

module afifo_tb;

    localparam int N_EQUAL     = 1500;                  // Writes at balanced rates
    localparam int N_SOAK      = 3000;                  // Both soak directions
    localparam int TOTAL_XFERS = N_EQUAL + `AFIFO_DEPTH + N_SOAK + 16;
    localparam int WATCHDOG_NS = TOTAL_XFERS * 40 + 2000;

    logic              wr_clk = 1'b0;
    logic              rd_clk = 1'b0;
    logic              RST;
    afifo_pkg::word_t  din;
    logic              wr_en;
    logic              rd_en;
    afifo_pkg::word_t  dout;
    logic              full;
    logic              empty;
    afifo_pkg::count_t wcount;
    afifo_pkg::count_t rcount;

    integer            seed = 32'h79c2;
    afifo_pkg::word_t  model_q [$];                     // Reference FIFO contents
    int                wr_pct = 0;                      // Write draw odds, percent
    int                rd_pct = 0;
    int                n_wr = 0;                        // Accepted writes
    int                n_read = 0;                      // Accepted reads
    int                n_checks = 0;
    int                errors = 0;

    afifo_144 uut (
        .wr_clk (wr_clk),
        .rd_clk (rd_clk),
        .RST    (RST),
        .din    (din),
        .wr_en  (wr_en),
        .rd_en  (rd_en),
        .dout   (dout),
        .full   (full),
        .empty  (empty),
        .wcount (wcount),
        .rcount (rcount)
    );

    bind afifo_144 afifo_chk chk (
        .wr_clk (wr_clk),
        .rd_clk (rd_clk),
        .RST    (RST),
        .we     (we),
        .full   (full),
        .empty  (empty),
        .wcount (wcount),
        .rcount (rcount)
    );

    always #3 wr_clk = ~wr_clk;                         // 6 ns, rising edges never meet rd_clk
    always #2 rd_clk = ~rd_clk;                         // 4 ns

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    task automatic check_val(input string what, input logic [143:0] actual,
                             input logic [143:0] expected);
        n_checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s at %0t: got 0x%0h, expected 0x%0h", what, $time, actual, expected);
        end
    endtask

    function automatic int draw_percent();
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'd100);                       // 0 to 99
    endfunction

    function automatic afifo_pkg::word_t draw_word();
        logic [159:0] bits;
        for (int i = 0; i < 5; i++) begin
            bits[i*32 +: 32] = $random(seed);
        end
        return bits[143:0];                             // Last draw half used
    endfunction

    // Empty the FIFO, then let both pointers settle across the clocks
    task automatic drain_all();
        repeat (2) @(negedge wr_clk);                   // Last drawn write lands
        rd_pct = 100;
        while (model_q.size() != 0) @(negedge rd_clk);
        repeat (8) @(negedge wr_clk);                   // Read pointer reaches write side
        check_val("empty", 144'(empty), 144'(1'b1));
        check_val("rcount", 144'(rcount), '0);
        check_val("full", 144'(full), 144'(1'b0));
        check_val("wcount", 144'(wcount), '0);
        rd_pct = 0;
    endtask

    task automatic run_traffic(input int wp, input int rp, input int n_writes);
        int target;
        target = n_wr + n_writes;
        wr_pct = wp;
        rd_pct = rp;
        while (n_wr < target) @(negedge wr_clk);
        wr_pct = 0;
        drain_all();
    endtask

    //////////////////////////////////////////////////
    // Drivers and monitors
    //////////////////////////////////////////////////
    always @(posedge wr_clk) begin
        wr_en <= (draw_percent() < wr_pct);
        din   <= draw_word();
    end

    always @(posedge rd_clk) begin
        rd_en <= (draw_percent() < rd_pct);
    end

    always @(posedge wr_clk) begin : wr_monitor
        int occ;
        int bound;
        occ   = model_q.size();
        bound = (occ > `AFIFO_DEPTH - 1) ? `AFIFO_DEPTH - 1 : occ;   // Capped at 511
        if (!RST) begin
            if (int'(wcount) < bound) check_val("wcount", 144'(wcount), 144'(bound));
            if (wr_en && !full) begin
                model_q.push_back(din);                 // Accepted write
                n_wr++;
            end
            if (model_q.size() > `AFIFO_DEPTH) begin
                check_val("model occupancy", 144'(model_q.size()), 144'(`AFIFO_DEPTH));
            end
        end
    end

    always @(posedge rd_clk) begin : rd_monitor
        int               occ;
        afifo_pkg::word_t head;
        occ = model_q.size();
        if (!RST) begin
            if (int'(rcount) > occ) check_val("rcount", 144'(rcount), 144'(occ));
            if (rd_en && !empty) begin
                if (occ == 0) begin
                    errors++;
                    $display("ERROR: read accepted at %0t with no word in the model", $time);
                end else begin
                    head = model_q.pop_front();
                    check_val("dout", dout, head);      // FWFT head before the pop
                    n_read++;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin : main_seq
        int base;
        RST   = 1'b1;
        din   = '0;
        wr_en = 1'b0;
        rd_en = 1'b0;
        repeat (5) @(posedge rd_clk);
        RST <= 1'b0;
        @(negedge rd_clk);
        check_val("empty", 144'(empty), 144'(1'b1));    // Reset state
        check_val("full", 144'(full), 144'(1'b0));
        check_val("wcount", 144'(wcount), '0);
        check_val("rcount", 144'(rcount), '0);

        run_traffic(50, 35, N_EQUAL);                   // Similar rates both sides

        wr_pct = 100;                                   // Fill, no reads
        while (!full) @(negedge wr_clk);
        repeat (16) @(negedge wr_clk);                  // Keep pushing against full
        check_val("model occupancy", 144'(model_q.size()), 144'(`AFIFO_DEPTH));
        check_val("full", 144'(full), 144'(1'b1));
        check_val("wcount", 144'(wcount), 144'(`AFIFO_DEPTH - 1));
        wr_pct = 0;
        drain_all();

        base   = n_read;                                // Reads against an empty FIFO
        rd_pct = 100;
        repeat (20) @(negedge rd_clk);
        check_val("reads while empty", 144'(n_read), 144'(base));
        check_val("empty", 144'(empty), 144'(1'b1));
        base   = n_wr;
        wr_pct = 100;
        while (n_wr == base) @(negedge wr_clk);
        wr_pct = 0;
        drain_all();                                    // New word is next out

        run_traffic(90, 20, N_SOAK / 2);                // Fast writer, slow reader
        run_traffic(20, 100, N_SOAK / 2);               // Slow writer, fast reader

        $display("Closing: %0d checks, %0d errors, %0d words written, %0d read",
                 n_checks, errors, n_wr, n_read);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("ERROR: timeout, the test sequence did not end within %0d ns", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hdl
hdl/afifo_pkg.sv
hdl/afifo_bank.sv
hdl/afifo_wr_side.sv
hdl/afifo_rd_side.sv
hdl/afifo_144.sv
bench/afifo_chk.sv
bench/afifo_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only -Wall --timing --assert
TOP       := afifo_tb
FLIST     := flist.f
LOG       := sim.log
FAIL_MSG  := Some tests failed
PASS_MSG  := All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)
